/* common/tile_defs.svh */
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// data path widths
`define TILE_DATA_WIDTH 32
`define TILE_MASK_WIDTH 4

// tile coordinates on the mesh
`define TILE_X_WIDTH 4
`define TILE_Y_WIDTH 4

// word address carried by remote stores
`define TILE_ADDR_WIDTH 14

// remote word addresses below this land in the core's imem
`define TILE_IMEM_WORDS 1024

// banked data memory geometry
`define TILE_NUM_BANKS 4
`define TILE_BANK_WORDS 256

// outbound remote stores in flight
`define TILE_MAX_CREDITS 8

`endif

/* common/tile_pkg.sv */
`include "tile_defs.svh"

package tile_pkg;

   // word address inside the whole banked dmem, bank select in the low bits
   typedef logic [$clog2(`TILE_NUM_BANKS*`TILE_BANK_WORDS)-1:0] dmem_addr_t;

   // core byte address, read as local dmem or as remote tile address
   typedef union packed
   {
      struct packed
      {
         logic                                  remote;
         logic [32-1-$clog2(`TILE_BANK_WORDS)-$clog2(`TILE_NUM_BANKS)-2-1:0] unused;
         logic [$clog2(`TILE_BANK_WORDS)-1:0]   index;
         logic [$clog2(`TILE_NUM_BANKS)-1:0]    bank;
         logic [1:0]                            byte_off;
      } loc;
      struct packed
      {
         logic                                  remote;
         logic [32-1-`TILE_Y_WIDTH-`TILE_X_WIDTH-`TILE_ADDR_WIDTH-2-1:0] unused;
         logic [`TILE_Y_WIDTH-1:0]              y;
         logic [`TILE_X_WIDTH-1:0]              x;
         logic [`TILE_ADDR_WIDTH-1:0]           addr;
         logic [1:0]                            byte_off;
      } rmt;
   } core_addr_u;

   // data memory port of the core
   typedef struct packed
   {
      logic                         valid;
      logic                         we;
      logic                         reserve;
      core_addr_u                   addr;
      logic [`TILE_DATA_WIDTH-1:0]  wdata;
      logic [`TILE_MASK_WIDTH-1:0]  mask;
   } core_req_s;

   // store arriving from the network
   typedef struct packed
   {
      logic [`TILE_ADDR_WIDTH-1:0]  addr;
      logic [`TILE_DATA_WIDTH-1:0]  data;
      logic [`TILE_MASK_WIDTH-1:0]  mask;
   } remote_store_s;

   typedef enum logic {INSTR = 1'b0, PC = 1'b1} net_op_e;

   // packet into the core's own network port
   typedef struct packed
   {
      logic                         valid;
      net_op_e                      op;
      logic [15:0]                  addr;
      logic [`TILE_MASK_WIDTH-1:0]  mask;
      logic [`TILE_DATA_WIDTH-1:0]  data;
   } core_net_pkt_s;

   // outbound remote store
   typedef struct packed
   {
      logic [`TILE_X_WIDTH-1:0]     x_dest;
      logic [`TILE_Y_WIDTH-1:0]     y_dest;
      logic [`TILE_X_WIDTH-1:0]     x_src;
      logic [`TILE_Y_WIDTH-1:0]     y_src;
      logic [`TILE_ADDR_WIDTH-1:0]  addr;
      logic [`TILE_MASK_WIDTH-1:0]  mask;
      logic [`TILE_DATA_WIDTH-1:0]  data;
   } out_pkt_s;

   // one crossbar port request
   typedef struct packed
   {
      logic                         valid;
      logic                         write;
      dmem_addr_t                   addr;
      logic [`TILE_DATA_WIDTH-1:0]  data;
      logic [`TILE_MASK_WIDTH-1:0]  mask;
   } bank_req_s;

endpackage

/* banked_mem/mem_bank.sv */
`timescale 1ns/1ps
`include "tile_defs.svh"

module mem_bank
   #(parameter els_p = `TILE_BANK_WORDS)
   (input                                 clk_i
   , input                                v_i
   , input                                w_i
   , input        [$clog2(els_p)-1:0]     addr_i
   , input        [`TILE_DATA_WIDTH-1:0]  data_i
   , input        [`TILE_MASK_WIDTH-1:0]  mask_i
   , output logic [`TILE_DATA_WIDTH-1:0]  data_o
   );

   logic [`TILE_DATA_WIDTH-1:0] mem [els_p];

   // one port, write or read per cycle
   always_ff @(posedge clk_i)
   begin
      if (v_i & w_i)
      begin
         // only enabled bytes change
         for (int b = 0; b < `TILE_MASK_WIDTH; b++)
         begin
            if (mask_i[b])
               mem[addr_i][8*b +: 8] <= data_i[8*b +: 8];
         end
      end
      else if (v_i)
         data_o <= mem[addr_i];
   end

   // index wider than the array when els_p is not a power of two
   addr_in_range_a: assert property (@(posedge clk_i) v_i |-> (addr_i < els_p));

endmodule

/* banked_mem/banked_mem_xbar.sv */
`timescale 1ns/1ps
`include "tile_defs.svh"

module banked_mem_xbar import tile_pkg::*;
   (input                                 clk_i
   , input                                reset_i
   , input  bank_req_s [1:0]              req_i
   , output logic [1:0]                   yumi_o
   , output logic                         rv_o
   , output logic [`TILE_DATA_WIDTH-1:0]  rdata_o
   );

   localparam int sel_w = $clog2(`TILE_NUM_BANKS);
   localparam int idx_w = $clog2(`TILE_BANK_WORDS);

   logic [1:0][sel_w-1:0]                port_bank;
   logic [1:0][`TILE_NUM_BANKS-1:0]      gnt;
   logic [`TILE_NUM_BANKS-1:0][`TILE_DATA_WIDTH-1:0] bank_rdata;

   logic                                 rv_r;
   logic [sel_w-1:0]                     bank_r;

   //////////////////////////////
   // arbitration
   //////////////////////////////

   // low word bits pick the bank
   assign port_bank[0] = req_i[0].addr[sel_w-1:0];
   assign port_bank[1] = req_i[1].addr[sel_w-1:0];

   // core port always wins, network port waits on a shared bank
   assign yumi_o[1] = req_i[1].valid;
   assign yumi_o[0] = req_i[0].valid
                    & ~(req_i[1].valid & (port_bank[0] == port_bank[1]));

   //////////////////////////////
   // banks
   //////////////////////////////

   for (genvar b = 0; b < `TILE_NUM_BANKS; b++)
   begin : bank
      bank_req_s sel;

      assign gnt[0][b] = yumi_o[0] & (port_bank[0] == sel_w'(b));
      assign gnt[1][b] = yumi_o[1] & (port_bank[1] == sel_w'(b));

      // route the granted port into this bank
      assign sel = gnt[1][b] ? req_i[1] : req_i[0];

      mem_bank #(.els_p(`TILE_BANK_WORDS)) mem
         (.clk_i  (clk_i)
         ,.v_i    (gnt[0][b] | gnt[1][b])
         ,.w_i    (sel.write)
         ,.addr_i (sel.addr[sel_w +: idx_w])
         ,.data_i (sel.data)
         ,.mask_i (sel.mask)
         ,.data_o (bank_rdata[b])
         );

      // both ports must never land in one bank together
      one_grant_a: assert property (@(posedge clk_i) disable iff (reset_i)
         !(gnt[0][b] && gnt[1][b]));
   end

   //////////////////////////////
   // port 1 read return
   //////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         rv_r <= 1'b0;
      else
         rv_r <= yumi_o[1] & ~req_i[1].write;
   end

   // which bank holds the read word next cycle
   always_ff @(posedge clk_i)
   begin
      if (yumi_o[1])
         bank_r <= port_bank[1];
   end

   assign rv_o    = rv_r;
   assign rdata_o = bank_rdata[bank_r];

endmodule

/* source/remote_store_encoder.sv */
`timescale 1ns/1ps
`include "tile_defs.svh"

module remote_store_encoder import tile_pkg::*;
   (input                               clk_i
   , input                              reset_i
   , input                              req_v_i
   , input  core_req_s                  req_i
   , input        [`TILE_X_WIDTH-1:0]   my_x_i
   , input        [`TILE_Y_WIDTH-1:0]   my_y_i
   , input                              out_ready_i
   , input                              credit_return_i
   , output logic                       out_v_o
   , output out_pkt_s                   out_pkt_o
   , output logic                       outstanding_o
   );

   localparam int cred_w = $clog2(`TILE_MAX_CREDITS + 1);

   logic [cred_w-1:0] credits_r;
   logic              launch;

   // packet fields straight from the remote address view
   assign out_pkt_o.x_dest = req_i.addr.rmt.x;
   assign out_pkt_o.y_dest = req_i.addr.rmt.y;
   assign out_pkt_o.x_src  = my_x_i;
   assign out_pkt_o.y_src  = my_y_i;
   assign out_pkt_o.addr   = req_i.addr.rmt.addr;
   assign out_pkt_o.mask   = req_i.mask;
   assign out_pkt_o.data   = req_i.wdata;

   // a packet needs at least one credit
   assign out_v_o = req_v_i & (credits_r != '0);
   assign launch  = out_v_o & out_ready_i;

   //////////////////////////////
   // credit counter
   //////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         credits_r <= cred_w'(`TILE_MAX_CREDITS);
      else if (launch & ~credit_return_i)
         credits_r <= credits_r - 1'b1;
      else if (~launch & credit_return_i)
         credits_r <= credits_r + 1'b1;
   end

   // stores still on their way somewhere
   assign outstanding_o = (credits_r < cred_w'(`TILE_MAX_CREDITS));

   // an empty counter may only stay empty or take back one returned credit
   no_launch_at_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (credits_r == '0) |=> (credits_r <= cred_w'(1)));

   // a return with nothing in flight would overflow the count
   credit_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
      credits_r <= cred_w'(`TILE_MAX_CREDITS));

endmodule

/* source/reservation_tracker.sv */
`timescale 1ns/1ps

module reservation_tracker import tile_pkg::*;
   (input                clk_i
   , input               reset_i
   , input               reserve_accept_i
   , input  dmem_addr_t  reserve_addr_i
   , input               store_accept_i
   , input  dmem_addr_t  store_addr_i
   , output logic        reservation_o
   );

   logic       reserved_r;
   dmem_addr_t addr_r;

   // load-reserved sets the flag, a remote store to that word drops it
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         reserved_r <= 1'b0;
      else if (reserve_accept_i)
         reserved_r <= 1'b1;
      else if (store_accept_i && (store_addr_i == addr_r))
         reserved_r <= 1'b0;
   end

   // word being watched
   always_ff @(posedge clk_i)
   begin
      if (reserve_accept_i)
         addr_r <= reserve_addr_i;
   end

   assign reservation_o = reserved_r;

endmodule

/* source/core_net_gen.sv */
`timescale 1ns/1ps

module core_net_gen import tile_pkg::*;
   (input                    clk_i
   , input                   reset_i
   , input                   freeze_i
   , input                   imem_v_i
   , input  remote_store_s   imem_store_i
   , output core_net_pkt_s   core_net_pkt_o
   , output logic            core_reset_o
   );

   logic freeze_r;
   logic freeze_rise;
   logic freeze_fall;

   // previous freeze level for edge detection
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= 1'b0;
      else
         freeze_r <= freeze_i;
   end

   assign freeze_rise = freeze_i & ~freeze_r;
   assign freeze_fall = ~freeze_i & freeze_r;

   // entering freeze parks the core
   assign core_reset_o = reset_i | freeze_rise;

   always_comb
   begin
      core_net_pkt_o.valid = imem_v_i | freeze_fall;
      if (imem_v_i)
      begin
         // instruction write, word address back to bytes
         core_net_pkt_o.op   = INSTR;
         core_net_pkt_o.addr = {imem_store_i.addr, 2'b00};
         core_net_pkt_o.mask = imem_store_i.mask;
         core_net_pkt_o.data = imem_store_i.data;
      end
      else
      begin
         // leaving freeze, start fetch at address zero
         core_net_pkt_o.op   = PC;
         core_net_pkt_o.addr = '0;
         core_net_pkt_o.mask = '0;
         core_net_pkt_o.data = '0;
      end
   end

endmodule

/* source/tile_shell_top.sv */
`timescale 1ns/1ps
`include "tile_defs.svh"

module tile_shell_top import tile_pkg::*;
   (input                                 clk_i
   , input                                reset_i
   , input        [`TILE_X_WIDTH-1:0]     my_x_i
   , input        [`TILE_Y_WIDTH-1:0]     my_y_i
   , input                                in_v_i
   , input  remote_store_s                in_store_i
   , output logic                         in_yumi_o
   , input  core_req_s                    core_req_i
   , output logic                         core_yumi_o
   , output logic                         core_rv_o
   , output logic [`TILE_DATA_WIDTH-1:0]  core_rdata_o
   , output core_net_pkt_s                core_net_pkt_o
   , output logic                         core_reset_o
   , output logic                         reservation_o
   , output logic                         out_v_o
   , output out_pkt_s                     out_pkt_o
   , input                                out_ready_i
   , input                                credit_return_i
   , input                                freeze_i
   , output logic                         outstanding_o
   );

   bank_req_s [1:0] xbar_req;
   logic [1:0]      xbar_yumi;
   logic            imem_store_v;
   logic            remote_req_v;

   //////////////////////////////
   // request decode
   //////////////////////////////

   // low remote word addresses are instructions
   assign imem_store_v = in_v_i & (in_store_i.addr < `TILE_ADDR_WIDTH'(`TILE_IMEM_WORDS));
   assign remote_req_v = core_req_i.valid & core_req_i.addr.rmt.remote;

   // port 0 takes the network stores, always a write
   assign xbar_req[0].valid = in_v_i & ~imem_store_v;
   assign xbar_req[0].write = 1'b1;
   assign xbar_req[0].addr  = in_store_i.addr[$bits(dmem_addr_t)-1:0];
   assign xbar_req[0].data  = in_store_i.data;
   assign xbar_req[0].mask  = in_store_i.mask;

   // port 1 takes local core accesses
   assign xbar_req[1].valid = core_req_i.valid & ~core_req_i.addr.loc.remote;
   assign xbar_req[1].write = core_req_i.we;
   assign xbar_req[1].addr  = {core_req_i.addr.loc.index, core_req_i.addr.loc.bank};
   assign xbar_req[1].data  = core_req_i.wdata;
   assign xbar_req[1].mask  = core_req_i.mask;

   assign in_yumi_o   = xbar_yumi[0] | imem_store_v;
   assign core_yumi_o = xbar_yumi[1] | (out_v_o & out_ready_i);

   banked_mem_xbar xbar
      (.clk_i, .reset_i, .req_i(xbar_req), .yumi_o(xbar_yumi)
      ,.rv_o(core_rv_o), .rdata_o(core_rdata_o));

   remote_store_encoder enc
      (.clk_i, .reset_i, .req_v_i(remote_req_v), .req_i(core_req_i)
      ,.my_x_i, .my_y_i, .out_ready_i, .credit_return_i
      ,.out_v_o, .out_pkt_o, .outstanding_o);

   // reservation only on a granted local reserve
   reservation_tracker resv
      (.clk_i, .reset_i
      ,.reserve_accept_i(xbar_yumi[1] & core_req_i.reserve), .reserve_addr_i(xbar_req[1].addr)
      ,.store_accept_i(xbar_yumi[0]), .store_addr_i(xbar_req[0].addr)
      ,.reservation_o);

   core_net_gen net_gen
      (.clk_i, .reset_i, .freeze_i, .imem_v_i(imem_store_v), .imem_store_i(in_store_i)
      ,.core_net_pkt_o, .core_reset_o);

endmodule

/* testbench/tile_shell_tb.sv */
`timescale 1ns/1ps
`include "tile_defs.svh"

module tile_shell_tb import tile_pkg::*; ();

   localparam int dmem_words = `TILE_NUM_BANKS * `TILE_BANK_WORDS;
   localparam int bank_w     = $clog2(`TILE_NUM_BANKS);
   localparam int idx_w      = $clog2(`TILE_BANK_WORDS);
   // base word address for dmem stores, well clear of the imem region
   localparam int dmem_base  = 4096;

   logic                         clk_i, reset_i;
   logic [`TILE_X_WIDTH-1:0]     my_x_i;
   logic [`TILE_Y_WIDTH-1:0]     my_y_i;
   logic                         in_v_i, in_yumi_o;
   remote_store_s                in_store_i;
   core_req_s                    core_req_i;
   logic                         core_yumi_o, core_rv_o;
   logic [`TILE_DATA_WIDTH-1:0]  core_rdata_o;
   core_net_pkt_s                core_net_pkt_o;
   logic                         core_reset_o, reservation_o;
   logic                         out_v_o, out_ready_i, credit_return_i;
   out_pkt_s                     out_pkt_o;
   logic                         freeze_i, outstanding_o;

   // expected dmem contents and credit count
   logic [`TILE_DATA_WIDTH-1:0]  shadow [dmem_words];
   int                           credits;
   logic [31:0]                  rand_state;

   tile_shell_top dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // ends the run well after the tests would have finished
   initial
   begin
      repeat (400) @(posedge clk_i);
      fail_now("watchdog expired before the tests finished");
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
         fail_now($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
   endtask

   // lcg with the numerical recipes constants
   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  mask);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++)
         if (mask[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      return res;
   endfunction

   // byte address of a dmem word with the bank in the low word bits
   function automatic core_addr_u local_addr(input int word);
      core_addr_u a;
      a = '0;
      a.loc.bank  = bank_w'(word % `TILE_NUM_BANKS);
      a.loc.index = idx_w'(word / `TILE_NUM_BANKS);
      return a;
   endfunction

   function automatic logic [`TILE_ADDR_WIDTH-1:0] dmem_store_addr(input int word);
      return `TILE_ADDR_WIDTH'(dmem_base + word);
   endfunction

   // drives one local request and drops it in the cycle after the grant
   task automatic core_issue(input logic we, input logic reserve, input int word,
                             input logic [31:0] wdata, input logic [3:0] mask);
      int waited;
      core_req_i         = '0;
      core_req_i.valid   = 1'b1;
      core_req_i.we      = we;
      core_req_i.reserve = reserve;
      core_req_i.addr    = local_addr(word);
      core_req_i.wdata   = wdata;
      core_req_i.mask    = mask;
      waited = 0;
      #1;
      while (!core_yumi_o && waited < 16)
      begin
         @(negedge clk_i);
         #1;
         waited++;
      end
      if (!core_yumi_o)
         fail_now("local core request was never accepted");
      @(negedge clk_i);
      core_req_i.valid = 1'b0;
   endtask

   task automatic core_write(input int word, input logic [31:0] data, input logic [3:0] mask);
      core_issue(1'b1, 1'b0, word, data, mask);
      shadow[word] = merge_bytes(shadow[word], data, mask);
      check_value("core_rv_o", core_rv_o, 1'b0);
   endtask

   // read data shows up for exactly one cycle
   task automatic core_read(input int word, input logic reserve);
      core_issue(1'b0, reserve, word, '0, '0);
      check_value("core_rv_o", core_rv_o, 1'b1);
      check_value("core_rdata_o", core_rdata_o, shadow[word]);
      @(negedge clk_i);
      check_value("core_rv_o", core_rv_o, 1'b0);
   endtask

   task automatic remote_store(input logic [`TILE_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] data, input logic [3:0] mask);
      int waited;
      in_v_i          = 1'b1;
      in_store_i.addr = addr;
      in_store_i.data = data;
      in_store_i.mask = mask;
      waited = 0;
      #1;
      while (!in_yumi_o && waited < 16)
      begin
         @(negedge clk_i);
         #1;
         waited++;
      end
      if (!in_yumi_o)
         fail_now("remote store was never accepted");
      @(negedge clk_i);
      in_v_i = 1'b0;
      if (addr >= `TILE_IMEM_WORDS)
         shadow[addr % dmem_words] = merge_bytes(shadow[addr % dmem_words], data, mask);
   endtask

   // one outbound cycle against the credit model
   task automatic outbound_cycle(input logic ready, input logic ret);
      logic exp_v;
      out_ready_i     = ready;
      credit_return_i = ret;
      #1;
      exp_v = core_req_i.valid && (credits > 0);
      check_value("out_v_o", out_v_o, exp_v);
      check_value("core_yumi_o", core_yumi_o, exp_v & ready);
      check_value("outstanding_o", outstanding_o, credits < `TILE_MAX_CREDITS);
      if (exp_v && ready)
         credits--;
      if (ret)
         credits++;
      @(negedge clk_i);
   endtask

   task automatic check_out_pkt(input logic [31:0] data);
      check_value("out_pkt_o.x_dest", out_pkt_o.x_dest, 4'd6);
      check_value("out_pkt_o.y_dest", out_pkt_o.y_dest, 4'd9);
      check_value("out_pkt_o.x_src", out_pkt_o.x_src, my_x_i);
      check_value("out_pkt_o.y_src", out_pkt_o.y_src, my_y_i);
      check_value("out_pkt_o.addr", out_pkt_o.addr, 14'h2a5);
      check_value("out_pkt_o.mask", out_pkt_o.mask, 4'b1101);
      check_value("out_pkt_o.data", out_pkt_o.data, data);
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////

   task automatic reset_values();
      #1;
      check_value("out_v_o", out_v_o, 1'b0);
      check_value("core_rv_o", core_rv_o, 1'b0);
      check_value("core_net_pkt_o.valid", core_net_pkt_o.valid, 1'b0);
      check_value("reservation_o", reservation_o, 1'b0);
      check_value("outstanding_o", outstanding_o, 1'b0);
      check_value("in_yumi_o", in_yumi_o, 1'b0);
      check_value("core_yumi_o", core_yumi_o, 1'b0);
      check_value("core_reset_o", core_reset_o, 1'b0);
      @(negedge clk_i);
   endtask

   // words 8, 17, 26, 35 sit in banks 0 to 3
   task automatic local_write_read();
      logic [3:0] masks [4];
      masks = '{4'b0101, 4'b0011, 4'b1000, 4'b0110};
      for (int i = 0; i < 4; i++)
      begin
         core_write(8 + 9*i, next_rand(), 4'hf);
         core_write(8 + 9*i, next_rand(), masks[i]);
      end
      for (int i = 0; i < 4; i++)
         core_read(8 + 9*i, 1'b0);
   endtask

   task automatic remote_dmem_and_conflict();
      logic [31:0] rdata, wdata;
      remote_store(dmem_store_addr(17), next_rand(), 4'b1100);
      core_read(17, 1'b0);
      // core read wins the shared bank and the store waits a cycle
      rdata = next_rand();
      in_v_i = 1'b1;
      in_store_i = '{addr: dmem_store_addr(40), data: rdata, mask: 4'hf};
      core_req_i = '{valid: 1'b1, we: 1'b0, reserve: 1'b0, addr: local_addr(8),
                     wdata: '0, mask: '0};
      #1;
      check_value("core_yumi_o", core_yumi_o, 1'b1);
      check_value("in_yumi_o", in_yumi_o, 1'b0);
      @(negedge clk_i);
      core_req_i.valid = 1'b0;
      #1;
      check_value("core_rv_o", core_rv_o, 1'b1);
      check_value("core_rdata_o", core_rdata_o, shadow[8]);
      check_value("in_yumi_o", in_yumi_o, 1'b1);
      @(negedge clk_i);
      in_v_i = 1'b0;
      shadow[40] = rdata;
      core_read(40, 1'b0);
      // different banks go through together
      rdata = next_rand();
      wdata = next_rand();
      in_v_i = 1'b1;
      in_store_i = '{addr: dmem_store_addr(41), data: rdata, mask: 4'hf};
      core_req_i = '{valid: 1'b1, we: 1'b1, reserve: 1'b0, addr: local_addr(8),
                     wdata: wdata, mask: 4'hf};
      #1;
      check_value("core_yumi_o", core_yumi_o, 1'b1);
      check_value("in_yumi_o", in_yumi_o, 1'b1);
      @(negedge clk_i);
      in_v_i = 1'b0;
      core_req_i.valid = 1'b0;
      shadow[41] = rdata;
      shadow[8] = wdata;
      core_read(41, 1'b0);
      core_read(8, 1'b0);
   endtask

   task automatic imem_and_freeze();
      logic [31:0] data;
      data = next_rand();
      in_v_i = 1'b1;
      in_store_i = '{addr: 14'd100, data: data, mask: 4'b1011};
      #1;
      check_value("in_yumi_o", in_yumi_o, 1'b1);
      check_value("core_net_pkt_o.valid", core_net_pkt_o.valid, 1'b1);
      check_value("core_net_pkt_o.op", core_net_pkt_o.op, INSTR);
      check_value("core_net_pkt_o.addr", core_net_pkt_o.addr, 16'd400);
      check_value("core_net_pkt_o.mask", core_net_pkt_o.mask, 4'b1011);
      check_value("core_net_pkt_o.data", core_net_pkt_o.data, data);
      @(negedge clk_i);
      in_v_i = 1'b0;
      freeze_i = 1'b1;
      #1;
      check_value("core_reset_o", core_reset_o, 1'b1);
      check_value("core_net_pkt_o.valid", core_net_pkt_o.valid, 1'b0);
      @(negedge clk_i);
      #1;
      check_value("core_reset_o", core_reset_o, 1'b0);
      @(negedge clk_i);
      freeze_i = 1'b0;
      #1;
      check_value("core_net_pkt_o.valid", core_net_pkt_o.valid, 1'b1);
      check_value("core_net_pkt_o.op", core_net_pkt_o.op, PC);
      check_value("core_net_pkt_o.addr", core_net_pkt_o.addr, 16'd0);
      check_value("core_net_pkt_o.mask", core_net_pkt_o.mask, 4'd0);
      check_value("core_net_pkt_o.data", core_net_pkt_o.data, 32'd0);
      @(negedge clk_i);
      #1;
      check_value("core_net_pkt_o.valid", core_net_pkt_o.valid, 1'b0);
      @(negedge clk_i);
   endtask

   task automatic outbound_credits();
      core_addr_u  dst;
      logic [31:0] data;
      data = next_rand();
      dst = '0;
      dst.rmt.remote = 1'b1;
      dst.rmt.y      = 4'd9;
      dst.rmt.x      = 4'd6;
      dst.rmt.addr   = 14'h2a5;
      core_req_i = '{valid: 1'b1, we: 1'b1, reserve: 1'b0, addr: dst,
                     wdata: data, mask: 4'b1101};
      out_ready_i = 1'b0;
      #1;
      check_out_pkt(data);
      @(negedge clk_i);
      // back-pressure holds the packet
      repeat (2) outbound_cycle(1'b0, 1'b0);
      #1;
      check_out_pkt(data);
      @(negedge clk_i);
      repeat (`TILE_MAX_CREDITS) outbound_cycle(1'b1, 1'b0);
      // out of credits
      outbound_cycle(1'b1, 1'b0);
      outbound_cycle(1'b1, 1'b1);
      outbound_cycle(1'b1, 1'b0);
      outbound_cycle(1'b1, 1'b0);
      core_req_i.valid = 1'b0;
      repeat (`TILE_MAX_CREDITS) outbound_cycle(1'b0, 1'b1);
      outbound_cycle(1'b0, 1'b0);
   endtask

   task automatic reservation_rules();
      core_write(60, next_rand(), 4'hf);
      core_read(60, 1'b1);
      check_value("reservation_o", reservation_o, 1'b1);
      // neighbour word leaves it alone
      remote_store(dmem_store_addr(61), next_rand(), 4'hf);
      check_value("reservation_o", reservation_o, 1'b1);
      remote_store(dmem_store_addr(60), next_rand(), 4'hf);
      check_value("reservation_o", reservation_o, 1'b0);
      core_read(60, 1'b0);
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial
   begin
      rand_state      = 32'h1266895f;
      credits         = `TILE_MAX_CREDITS;
      reset_i         = 1'b1;
      my_x_i          = 4'd3;
      my_y_i          = 4'd5;
      in_v_i          = 1'b0;
      in_store_i      = '0;
      core_req_i      = '0;
      out_ready_i     = 1'b0;
      credit_return_i = 1'b0;
      freeze_i        = 1'b0;
      repeat (5) @(negedge clk_i);
      reset_i = 1'b0;
      reset_values();
      local_write_read();
      remote_dmem_and_conflict();
      imem_and_freeze();
      outbound_credits();
      reservation_rules();
      $display("Testbench passed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+common
common/tile_pkg.sv
banked_mem/mem_bank.sv
banked_mem/banked_mem_xbar.sv
source/remote_store_encoder.sv
source/reservation_tracker.sv
source/core_net_gen.sv
source/tile_shell_top.sv
testbench/tile_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tile shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tile_shell_tb -Mdir obj_dir -o tile_shell_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/tile_shell_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error status, see $LOG"
fi

if grep -q "^Testbench passed$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL, see $LOG"
   exit 1
fi
